//--- verilog/touch_pkg.sv
// Raw 12-bit ADC codes, no calibration; keypad keys exist only where y has its top bit set
`default_nettype none

package touch_pkg;

	//====================================================================
	// ADC serial frame
	//====================================================================
	typedef logic [11:0] coord_t;					// Raw panel coordinate

	localparam int ADC_CLK_DIV = 4;					// Sys clocks per dclk half period
	localparam int FRAME_CLKS = 24;					// Serial clocks per conversion
	localparam int CMD_BITS = 8;					// Command byte, MSB first
	localparam int DATA_FIRST_CLK = 10;				// Rising edge of result MSB

	// Start bit, channel, 12-bit differential, power down between conversions
	localparam logic [CMD_BITS-1:0] CMD_X = 8'h90;	// Channel 001
	localparam logic [CMD_BITS-1:0] CMD_Y = 8'hD0;	// Channel 101

	//====================================================================
	// Keypad zones
	//====================================================================
	typedef logic [2:0] key_t;						// 0..5 colours, then clear, submit

	localparam key_t KEY_CLEAR = 3'd6;				// Empties the guess row
	localparam key_t KEY_SUBMIT = 3'd7;				// Scores a full row

endpackage

`default_nettype wire

//--- verilog/mastermind_pkg.sv
// Colour codes 6 and 7 exist on the switches but no key can enter them in a guess
`default_nettype none

package mastermind_pkg;

	//====================================================================
	// Game dimensions
	//====================================================================
	typedef logic [2:0] colour_t;					// Peg colour
	localparam int NUM_COLOURS = 6;					// Playable colours
	localparam int CODE_LEN = 4;					// Slots per row
	localparam int MAX_ROWS = 8;					// Rows before the game is lost

	typedef colour_t [CODE_LEN-1:0] code_t;			// Slot 0 in the low bits
	typedef logic [2:0] peg_count_t;				// 0..4 pegs
	typedef logic [3:0] row_t;						// 0..8 rows used

	localparam int RESET_HOLD = 16;					// Internal reset stretch

	//====================================================================
	// Seven-segment display
	//====================================================================
	typedef logic [6:0] seg7_t;						// Active low, bit 0 is segment a
	typedef logic [3:0] digit_t;					// Hex value per digit
	localparam int NUM_DIGITS = 8;

	localparam seg7_t SEG7_BLANK = 7'b1111111;		// All segments off

	localparam seg7_t SEG7_HEX [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,	// 0 1 2 3
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,	// 4 5 6 7
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,	// 8 9 A b
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110	// C d E F
	};

endpackage

`default_nettype wire

//--- verilog/reset_delay.sv
// Release of rst_n is assumed to happen away from an iCLK_50 edge; assertion stays asynchronous
`default_nettype none
`timescale 1ns/1ps

module reset_delay
(
	input  logic iCLK_50,
	input  logic rst_n,								// Board reset, active low
	output logic sys_rst_n							// Stretched internal reset
);

	localparam int CNT_W = $clog2(mastermind_pkg::RESET_HOLD);

	logic [CNT_W-1:0] hold_cnt;						// Cycles since release

	always_ff @(posedge iCLK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hold_cnt <= '0;
			sys_rst_n <= 1'b0;
		end
		else if (!sys_rst_n)
		begin
			if (hold_cnt == CNT_W'(mastermind_pkg::RESET_HOLD - 1))
				sys_rst_n <= 1'b1;					// Release on the last count
			else
				hold_cnt <= hold_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/adc_spi_controller.sv
// adc_penirq_n and adc_dout are sampled unsynchronized; fixed frame, ADC busy line not used
`default_nettype none
`timescale 1ns/1ps

module adc_spi_controller
(
	input  logic iCLK_50,
	input  logic sys_rst_n,
	input  logic adc_penirq_n,						// Pen down, active low
	input  logic adc_dout,							// Serial result from ADC
	output logic adc_din,							// Serial command to ADC
	output logic adc_dclk,							// Serial clock, idles low
	output logic adc_cs,							// Chip select, active low
	output logic new_coord,							// One-cycle pair strobe
	output touch_pkg::coord_t x_coord,
	output touch_pkg::coord_t y_coord
);

	localparam int DIV_W = $clog2(touch_pkg::ADC_CLK_DIV);
	localparam int CNT_W = $clog2(touch_pkg::FRAME_CLKS + 1);
	localparam int COORD_W = $bits(touch_pkg::coord_t);

	typedef enum logic [2:0] {S_IDLE, S_XFRAME, S_GAP, S_YFRAME, S_PUBLISH} state_t;

	state_t state;
	logic [DIV_W-1:0] div_cnt;						// Half-period divider
	logic [CNT_W-1:0] clk_num;						// Current serial clock, 1-based
	logic [touch_pkg::CMD_BITS-1:0] cmd_sr;			// Outgoing command
	touch_pkg::coord_t data_sr;						// Incoming result
	touch_pkg::coord_t x_hold;						// X result until Y is done
	logic tick, in_frame, rise_tick, fall_tick, frame_done, sample, load_x, load_y;

	assign tick = (div_cnt == DIV_W'(touch_pkg::ADC_CLK_DIV - 1));
	assign in_frame = (state == S_XFRAME) || (state == S_YFRAME);
	assign rise_tick = tick && in_frame && !adc_dclk;
	assign fall_tick = tick && in_frame && adc_dclk;
	assign frame_done = fall_tick && (clk_num == CNT_W'(touch_pkg::FRAME_CLKS));
	assign sample = rise_tick && (clk_num >= CNT_W'(touch_pkg::DATA_FIRST_CLK))
		&& (clk_num < CNT_W'(touch_pkg::DATA_FIRST_CLK + COORD_W));	// 12 result bits
	assign load_x = (state == S_IDLE) && !adc_penirq_n;
	assign load_y = (state == S_GAP) && tick;
	assign adc_din = !adc_cs && cmd_sr[touch_pkg::CMD_BITS-1];	// Low outside frames

	//====================================================================
	// Frame sequencing
	//====================================================================
	always_ff @(posedge iCLK_50 or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			state <= S_IDLE;
			div_cnt <= '0;
			clk_num <= '0;
			adc_dclk <= 1'b0;
			adc_cs <= 1'b1;
			new_coord <= 1'b0;
		end
		else
		begin
			new_coord <= 1'b0;
			div_cnt <= (state == S_IDLE || tick) ? '0 : div_cnt + 1'b1;	// Restarts per frame
			case (state)
				S_IDLE:
					if (load_x)
					begin
						state <= S_XFRAME;
						adc_cs <= 1'b0;
						clk_num <= CNT_W'(1);
					end
				S_XFRAME, S_YFRAME:
					if (tick)
					begin
						adc_dclk <= !adc_dclk;
						if (frame_done)
						begin
							adc_cs <= 1'b1;			// Deselect between frames
							state <= (state == S_XFRAME) ? S_GAP : S_PUBLISH;
						end
						else if (adc_dclk)
							clk_num <= clk_num + 1'b1;	// Next clock after falling edge
					end
				S_GAP:
					if (load_y)
					begin
						state <= S_YFRAME;
						adc_cs <= 1'b0;
						clk_num <= CNT_W'(1);
					end
				S_PUBLISH:
				begin
					new_coord <= 1'b1;				// Same cycle as new x/y
					state <= S_IDLE;				// Repeats while pen stays down
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	//====================================================================
	// Command and result shifting
	//====================================================================
	always_ff @(posedge iCLK_50)
	begin
		if (load_x)
			cmd_sr <= touch_pkg::CMD_X;
		else if (load_y)
			cmd_sr <= touch_pkg::CMD_Y;
		else if (fall_tick)
			cmd_sr <= {cmd_sr[touch_pkg::CMD_BITS-2:0], 1'b0};	// Change while dclk low
		if (sample)
			data_sr <= {data_sr[COORD_W-2:0], adc_dout};	// MSB first
		if (frame_done && state == S_XFRAME)
			x_hold <= data_sr;
		if (state == S_PUBLISH)
		begin
			x_coord <= x_hold;
			y_coord <= data_sr;
		end
	end

endmodule

`default_nettype wire

//--- verilog/touch_zone_decoder.sv
// The first coordinate pair of a press decides; a press starting in the lower half gives no key
`default_nettype none
`timescale 1ns/1ps

module touch_zone_decoder
(
	input  logic iCLK_50,
	input  logic sys_rst_n,
	input  logic adc_penirq_n,						// High again rearms
	input  logic new_coord,
	input  touch_pkg::coord_t x_coord,
	input  touch_pkg::coord_t y_coord,
	output logic key_valid,							// One pulse per press
	output touch_pkg::key_t key
);

	localparam int COORD_W = $bits(touch_pkg::coord_t);
	localparam int KEY_W = $bits(touch_pkg::key_t);

	logic armed;									// No key yet in this press
	logic keypad_hit;

	assign keypad_hit = y_coord[COORD_W-1];			// Upper half of the panel

	always_ff @(posedge iCLK_50 or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			armed <= 1'b1;
			key_valid <= 1'b0;
		end
		else
		begin
			key_valid <= 1'b0;
			if (adc_penirq_n)
				armed <= 1'b1;						// Pen lifted
			else if (new_coord && armed)
			begin
				armed <= 1'b0;
				key_valid <= keypad_hit;
			end
		end
	end

	// Column band from the top bits of x, eight keys across
	always_ff @(posedge iCLK_50)
	begin
		if (new_coord && armed)
			key <= x_coord[COORD_W-1 -: KEY_W];
	end

endmodule

`default_nettype wire

//--- verilog/peg_scorer.sv
// Only colours below NUM_COLOURS count for white; black and white are valid only with score_valid
`default_nettype none
`timescale 1ns/1ps

module peg_scorer
(
	input  logic iCLK_50,
	input  logic sys_rst_n,
	input  logic score_start,						// Guess and secret stable
	input  mastermind_pkg::code_t guess,
	input  mastermind_pkg::code_t secret,
	output logic score_valid,						// One cycle after start
	output mastermind_pkg::peg_count_t black,
	output mastermind_pkg::peg_count_t white
);

	mastermind_pkg::peg_count_t black_c;			// Exact position matches
	mastermind_pkg::peg_count_t match_c;			// Colour matches anywhere
	mastermind_pkg::peg_count_t g_cnt, s_cnt;		// Per-colour occurrences

	always_comb
	begin
		black_c = '0;
		match_c = '0;
		g_cnt = '0;
		s_cnt = '0;
		for (int i = 0; i < mastermind_pkg::CODE_LEN; i++)
			if (guess[i] == secret[i])
				black_c = black_c + 3'd1;
		for (int c = 0; c < mastermind_pkg::NUM_COLOURS; c++)
		begin
			g_cnt = '0;
			s_cnt = '0;
			for (int i = 0; i < mastermind_pkg::CODE_LEN; i++)
			begin
				if (guess[i] == mastermind_pkg::colour_t'(c))
					g_cnt = g_cnt + 3'd1;
				if (secret[i] == mastermind_pkg::colour_t'(c))
					s_cnt = s_cnt + 3'd1;
			end
			match_c = match_c + ((g_cnt < s_cnt) ? g_cnt : s_cnt);	// Smaller count
		end
	end

	always_ff @(posedge iCLK_50 or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
			score_valid <= 1'b0;
		else
			score_valid <= score_start;
	end

	always_ff @(posedge iCLK_50)
	begin
		if (score_start)
		begin
			black <= black_c;
			white <= match_c - black_c;				// Blacks are in the match total
		end
	end

endmodule

`default_nettype wire

//--- verilog/mastermind_game.sv
// start_n is a debounced level; keys outside play, during scoring or after the end are dropped
`default_nettype none
`timescale 1ns/1ps

module mastermind_game
(
	input  logic iCLK_50,
	input  logic sys_rst_n,
	input  logic start_n,							// Falling edge starts a game
	input  mastermind_pkg::code_t secret_sw,
	input  logic key_valid,
	input  touch_pkg::key_t key,
	output logic led_win,
	output logic led_lose,
	output mastermind_pkg::digit_t [mastermind_pkg::NUM_DIGITS-1:0] digit_value,
	output logic [mastermind_pkg::NUM_DIGITS-1:0] digit_blank	// 1 turns a digit off
);

	localparam int SLOT_W = $clog2(mastermind_pkg::CODE_LEN + 1);
	localparam int IDX_W = $clog2(mastermind_pkg::CODE_LEN);

	typedef enum logic [2:0] {ST_IDLE, ST_PLAY, ST_SCORE, ST_WON, ST_LOST} state_t;

	state_t state;
	logic start_q;									// start_n last cycle
	logic [SLOT_W-1:0] slot_cnt;					// Filled slots
	mastermind_pkg::code_t guess_slots;
	mastermind_pkg::code_t secret_code;
	mastermind_pkg::row_t rows;						// Rows scored so far
	mastermind_pkg::peg_count_t last_black, last_white;	// Shown result
	logic score_start, score_valid;
	mastermind_pkg::peg_count_t black, white;
	logic start_fall, play_key, add_colour;

	assign start_fall = start_q && !start_n;
	assign play_key = key_valid && (state == ST_PLAY);
	assign add_colour = play_key && (int'(key) < mastermind_pkg::NUM_COLOURS)
		&& (slot_cnt < SLOT_W'(mastermind_pkg::CODE_LEN));	// Fifth colour ignored
	assign led_win = (state == ST_WON);
	assign led_lose = (state == ST_LOST);

	peg_scorer i_peg_scorer
	(
		.iCLK_50     (iCLK_50),
		.sys_rst_n   (sys_rst_n),
		.score_start (score_start),
		.guess       (guess_slots),
		.secret      (secret_code),
		.score_valid (score_valid),
		.black       (black),
		.white       (white)
	);

	//====================================================================
	// Game FSM
	//====================================================================
	always_ff @(posedge iCLK_50 or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
		begin
			state <= ST_IDLE;
			start_q <= 1'b1;
			slot_cnt <= '0;
			rows <= '0;
			last_black <= '0;
			last_white <= '0;
			score_start <= 1'b0;
		end
		else
		begin
			start_q <= start_n;
			score_start <= 1'b0;
			if (start_fall)
			begin
				state <= ST_PLAY;					// Also restarts a running game
				slot_cnt <= '0;
				rows <= '0;
				last_black <= '0;
				last_white <= '0;
			end
			else
			begin
				case (state)
					ST_PLAY:
						if (add_colour)
							slot_cnt <= slot_cnt + 1'b1;
						else if (play_key && key == touch_pkg::KEY_CLEAR)
							slot_cnt <= '0;
						else if (play_key && key == touch_pkg::KEY_SUBMIT
							&& slot_cnt == SLOT_W'(mastermind_pkg::CODE_LEN))
						begin
							score_start <= 1'b1;	// Slots frozen while scoring
							state <= ST_SCORE;
						end
					ST_SCORE:
						if (score_valid)
						begin
							last_black <= black;
							last_white <= white;
							rows <= rows + 1'b1;
							slot_cnt <= '0;
							if (black == mastermind_pkg::peg_count_t'(mastermind_pkg::CODE_LEN))
								state <= ST_WON;
							else if (rows + 1'b1 == mastermind_pkg::row_t'(mastermind_pkg::MAX_ROWS))
								state <= ST_LOST;	// Last row used up
							else
								state <= ST_PLAY;
						end
					default: state <= state;		// Idle, won, lost wait for start
				endcase
			end
		end
	end

	always_ff @(posedge iCLK_50)
	begin
		if (start_fall)
			secret_code <= secret_sw;
		if (add_colour)
			guess_slots[slot_cnt[IDX_W-1:0]] <= mastermind_pkg::colour_t'(key);
	end

	//====================================================================
	// Digit mapping
	//====================================================================
	always_comb
	begin
		digit_value = '0;
		digit_blank = '0;
		digit_value[0] = {1'b0, last_black};
		digit_value[1] = {1'b0, last_white};
		digit_value[2] = rows;
		digit_blank[3] = 1'b1;						// Spacer
		for (int i = 0; i < mastermind_pkg::CODE_LEN; i++)
		begin
			digit_value[4+i] = {1'b0, guess_slots[i]};
			digit_blank[4+i] = (slot_cnt <= SLOT_W'(i));	// Empty slot
		end
	end

endmodule

`default_nettype wire

//--- verilog/seg7_display.sv
// Common-anode digits, segment bit 0 is a; decimal points are not driven
`default_nettype none
`timescale 1ns/1ps

module seg7_display
(
	input  logic iCLK_50,
	input  logic sys_rst_n,
	input  mastermind_pkg::digit_t [mastermind_pkg::NUM_DIGITS-1:0] digit_value,
	input  logic [mastermind_pkg::NUM_DIGITS-1:0] digit_blank,
	output mastermind_pkg::seg7_t [mastermind_pkg::NUM_DIGITS-1:0] hex
);

	always_ff @(posedge iCLK_50 or negedge sys_rst_n)
	begin
		if (!sys_rst_n)
			hex <= {mastermind_pkg::NUM_DIGITS{mastermind_pkg::SEG7_BLANK}};	// Dark
		else
		begin
			for (int i = 0; i < mastermind_pkg::NUM_DIGITS; i++)
			begin
				if (digit_blank[i])
					hex[i] <= mastermind_pkg::SEG7_BLANK;
				else
					hex[i] <= mastermind_pkg::SEG7_HEX[digit_value[i]];	// Hex lookup
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/mastermind_top.sv
// Board pins are mapped outside this level; rst_n and start_n come from debounced keys
`default_nettype none
`timescale 1ns/1ps

module mastermind_top
(
	input  logic iCLK_50,							// 50 MHz board clock
	input  logic rst_n,
	input  logic start_n,
	input  mastermind_pkg::code_t secret_sw,
	input  logic adc_penirq_n,
	input  logic adc_dout,
	output logic adc_din,
	output logic adc_dclk,
	output logic adc_cs,
	output mastermind_pkg::seg7_t [mastermind_pkg::NUM_DIGITS-1:0] hex,
	output logic led_win,
	output logic led_lose
);

	logic sys_rst_n;
	logic new_coord, key_valid;
	touch_pkg::coord_t x_coord, y_coord;
	touch_pkg::key_t key;
	mastermind_pkg::digit_t [mastermind_pkg::NUM_DIGITS-1:0] digit_value;
	logic [mastermind_pkg::NUM_DIGITS-1:0] digit_blank;

	reset_delay i_reset_delay (.iCLK_50(iCLK_50), .rst_n(rst_n), .sys_rst_n(sys_rst_n));

	adc_spi_controller i_adc_spi_controller
	(
		.iCLK_50 (iCLK_50), .sys_rst_n (sys_rst_n), .adc_penirq_n (adc_penirq_n),
		.adc_dout (adc_dout), .adc_din (adc_din), .adc_dclk (adc_dclk),
		.adc_cs (adc_cs), .new_coord (new_coord), .x_coord (x_coord), .y_coord (y_coord)
	);

	touch_zone_decoder i_touch_zone_decoder
	(
		.iCLK_50 (iCLK_50), .sys_rst_n (sys_rst_n), .adc_penirq_n (adc_penirq_n),
		.new_coord (new_coord), .x_coord (x_coord), .y_coord (y_coord),
		.key_valid (key_valid), .key (key)
	);

	mastermind_game i_mastermind_game
	(
		.iCLK_50 (iCLK_50), .sys_rst_n (sys_rst_n), .start_n (start_n),
		.secret_sw (secret_sw), .key_valid (key_valid), .key (key),
		.led_win (led_win), .led_lose (led_lose),
		.digit_value (digit_value), .digit_blank (digit_blank)
	);

	seg7_display i_seg7_display
	(
		.iCLK_50 (iCLK_50), .sys_rst_n (sys_rst_n),
		.digit_value (digit_value), .digit_blank (digit_blank), .hex (hex)
	);

endmodule

`default_nettype wire

//--- tb/mastermind_assertions.sv
// Checks the game state registers only; results are meaningful once sys_rst_n is released
`default_nettype none
`timescale 1ns/1ps

module mastermind_assertions
(
	input  logic iCLK_50,
	input  logic sys_rst_n,
	input  logic led_win,
	input  logic led_lose,
	input  mastermind_pkg::row_t rows,
	input  mastermind_pkg::peg_count_t last_black,
	input  mastermind_pkg::peg_count_t last_white
);

	int fail_count = 0;								// Failed invariants so far

	//======================================================================
	// Game invariants
	//======================================================================
	peg_total: assert property (@(posedge iCLK_50) disable iff (!sys_rst_n)
		({1'b0, last_black} + {1'b0, last_white}) <= 4'd4)	// Never more pegs than slots
		else
		begin
			fail_count = fail_count + 1;
			$error("black plus white exceeds four");
		end

	win_pegs: assert property (@(posedge iCLK_50) disable iff (!sys_rst_n)
		led_win |-> (last_black == 3'd4))
		else
		begin
			fail_count = fail_count + 1;
			$error("win without four black pegs");
		end

	row_limit: assert property (@(posedge iCLK_50) disable iff (!sys_rst_n)
		rows <= mastermind_pkg::row_t'(mastermind_pkg::MAX_ROWS))
		else
		begin
			fail_count = fail_count + 1;
			$error("row count above limit");
		end

	one_end: assert property (@(posedge iCLK_50) disable iff (!sys_rst_n)
		!(led_win && led_lose))						// Won and lost exclude each other
		else
		begin
			fail_count = fail_count + 1;
			$error("win and lose both high");
		end

endmodule

bind mastermind_game mastermind_assertions i_mastermind_assertions
(
	.iCLK_50 (iCLK_50), .sys_rst_n (sys_rst_n), .led_win (led_win), .led_lose (led_lose),
	.rows (rows), .last_black (last_black), .last_white (last_white)
);

`default_nettype wire

//--- tb/tb_mastermind.sv
// Reads tb/mastermind_vectors.txt from the project root; one key per press, about 10 us per press
`default_nettype none
`timescale 1ns/1ps

module tb_mastermind;

	localparam int VEC_MAX = 256;						// Room in the vector memory
	localparam int NS_PER_VEC = 200000;					// Watchdog budget per vector
	localparam touch_pkg::coord_t Y_KEYPAD = 12'd3000;	// Upper half, top bit set
	localparam touch_pkg::coord_t Y_LOWER = 12'd1000;	// Lower half, no key
	localparam mastermind_pkg::seg7_t BLANK = 7'h7F;	// All segments off

	logic iCLK_50 = 1'b0;
	logic rst_n = 1'b0;
	logic start_n = 1'b1;
	mastermind_pkg::code_t secret_sw = '0;
	logic adc_penirq_n = 1'b1;							// Pen up
	logic adc_dout = 1'b0;
	logic adc_din, adc_dclk, adc_cs;
	mastermind_pkg::seg7_t [mastermind_pkg::NUM_DIGITS-1:0] hex;
	logic led_win, led_lose;

	logic [31:0] vec [VEC_MAX];							// Operation words
	int vec_count = 0;
	touch_pkg::coord_t pen_x = '0, pen_y = '0;			// Position under the pen
	logic [7:0] cmd_rx = '0;							// Command seen by the ADC model
	int dclk_num = 0;									// Serial clock within a frame
	logic y_frame = 1'b0;								// Next frame carries the Y command

	mastermind_top i_mastermind_top
	(
		.iCLK_50 (iCLK_50), .rst_n (rst_n), .start_n (start_n), .secret_sw (secret_sw),
		.adc_penirq_n (adc_penirq_n), .adc_dout (adc_dout), .adc_din (adc_din),
		.adc_dclk (adc_dclk), .adc_cs (adc_cs), .hex (hex),
		.led_win (led_win), .led_lose (led_lose)
	);

	always #5 iCLK_50 = ~iCLK_50;						// 10 ns period

	//======================================================================
	// ADC pen model
	//======================================================================
	always @(posedge adc_dclk)
	begin
		dclk_num = (dclk_num % touch_pkg::FRAME_CLKS) + 1;	// Frames are a fixed length
		if (dclk_num <= touch_pkg::CMD_BITS)
			cmd_rx = {cmd_rx[6:0], adc_din};			// Command MSB first
		if (dclk_num == touch_pkg::CMD_BITS)
		begin
			check_cmd("adc_din command", y_frame ? touch_pkg::CMD_Y : touch_pkg::CMD_X,
				cmd_rx);								// X frame, then Y frame
			y_frame = !y_frame;
		end
	end

	always @(negedge adc_dclk)
	begin
		touch_pkg::coord_t axis;
		axis = (cmd_rx[6:4] == 3'b101) ? pen_y : pen_x;	// Channel 101 is Y
		if (dclk_num + 1 >= touch_pkg::DATA_FIRST_CLK
			&& dclk_num + 1 < touch_pkg::DATA_FIRST_CLK + 12)
			adc_dout <= axis[touch_pkg::DATA_FIRST_CLK + 10 - dclk_num];	// Next result bit
		else
			adc_dout <= 1'b0;
	end

	//======================================================================
	// Segment table and compare tasks
	//======================================================================
	function automatic mastermind_pkg::seg7_t seg_of(input int v);
		logic [6:0] lit;								// Lit segments, bit 0 is a
		case (v)
			0: lit = 7'h3F;
			1: lit = 7'h06;
			2: lit = 7'h5B;
			3: lit = 7'h4F;
			4: lit = 7'h66;
			5: lit = 7'h6D;
			6: lit = 7'h7D;
			7: lit = 7'h07;
			8: lit = 7'h7F;
			9: lit = 7'h6F;
			default: lit = 7'h00;
		endcase
		return ~lit;									// Active low
	endfunction

	function automatic int decode_seg(input mastermind_pkg::seg7_t seg);
		for (int v = 0; v < 10; v++)
			if (seg_of(v) == seg)
				return v;
		return -1;										// Not a decimal digit
	endfunction

	function automatic touch_pkg::coord_t key_x(input logic [2:0] k);
		return touch_pkg::coord_t'(int'(k) * 512 + 256);	// Middle of the key band
	endfunction

	task automatic fail_now(input string what);
		$display("*** FAILED ***");
		$fatal(1, "%s", what);
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp)
		begin
			$display("ERROR %0d ns %s expected %b got %b", $time, name, exp, got);
			fail_now("flag mismatch");
		end
	endtask

	task automatic check_digit(input string name, input mastermind_pkg::seg7_t exp,
		input mastermind_pkg::seg7_t got);
		if (got !== exp)
		begin
			$display("ERROR %0d ns %s expected %b got %b", $time, name, exp, got);
			fail_now("digit mismatch");
		end
	endtask

	task automatic check_pegs(input string name, input mastermind_pkg::peg_count_t exp,
		input mastermind_pkg::seg7_t got);
		int val;
		val = decode_seg(got);
		if (val != int'(exp))
		begin
			$display("ERROR %0d ns %s expected %0d got %0d (%b)", $time, name, exp, val, got);
			fail_now("peg count mismatch");
		end
	endtask

	task automatic check_cmd(input string name, input logic [touch_pkg::CMD_BITS-1:0] exp,
		input logic [touch_pkg::CMD_BITS-1:0] got);
		if (got !== exp)
		begin
			$display("ERROR %0d ns %s expected %h got %h", $time, name, exp, got);
			fail_now("ADC command mismatch");
		end
	endtask

	//======================================================================
	// Stimulus tasks
	//======================================================================
	task automatic press(input touch_pkg::coord_t x, input touch_pkg::coord_t y, input int pairs);
		int quiet;
		pen_x = x;
		pen_y = y;
		@(posedge iCLK_50);
		adc_penirq_n <= 1'b0;
		repeat (2 * pairs) @(posedge adc_cs);			// X and Y frame per pair
		repeat (2) @(posedge iCLK_50);					// Let the decoder see the pair
		adc_penirq_n <= 1'b1;
		quiet = 0;
		while (quiet < 50)								// Trailing frames drain first
		begin
			@(negedge iCLK_50);
			quiet = adc_cs ? quiet + 1 : 0;
		end
	endtask

	task automatic start_game(input mastermind_pkg::code_t code);
		@(posedge iCLK_50);
		secret_sw <= code;
		start_n <= 1'b0;
		repeat (2) @(posedge iCLK_50);
		start_n <= 1'b1;
		repeat (5) @(posedge iCLK_50);
	endtask

	task automatic check_result(input logic [31:0] w);
		@(negedge iCLK_50);
		check_pegs("black digit", mastermind_pkg::peg_count_t'(w[18:16]), hex[0]);
		check_pegs("white digit", mastermind_pkg::peg_count_t'(w[14:12]), hex[1]);
		check_digit("rows digit", seg_of(int'(w[11:8])), hex[2]);
		check_digit("digit 3", BLANK, hex[3]);
		check_flag("led_win", w[4], led_win);
		check_flag("led_lose", w[0], led_lose);
	endtask

	task automatic check_guess(input logic [31:0] w);
		@(negedge iCLK_50);
		for (int i = 0; i < 4; i++)
			check_digit($sformatf("guess digit %0d", 4 + i),
				(i < int'(w[19:16])) ? seg_of(int'(w[14-4*i -: 3])) : BLANK, hex[4+i]);
	endtask

	//======================================================================
	// Main sequence and watchdog
	//======================================================================
	initial
	begin
		wait (vec_count > 0);
		#(longint'(vec_count) * NS_PER_VEC);
		$display("Run timed out before the vectors were done");
		fail_now("watchdog expired");
	end

	always @(negedge iCLK_50)
	begin
		if (i_mastermind_top.i_mastermind_game.i_mastermind_assertions.fail_count > 0)
			fail_now("a bound assertion in mastermind_game failed");
	end

	initial
	begin
		logic [31:0] w;
		mastermind_pkg::code_t code;
		int n;
		$readmemh("tb/mastermind_vectors.txt", vec);
		n = 0;
		while (n < VEC_MAX && !$isunknown(vec[n]) && vec[n][31:28] != 4'hF)
			n++;
		if (n == 0 || n == VEC_MAX || $isunknown(vec[n]))
			fail_now("vector file missing or without end marker");
		vec_count = n;
		repeat (2) @(posedge iCLK_50);
		rst_n <= 1'b1;
		repeat (mastermind_pkg::RESET_HOLD + 8) @(posedge iCLK_50);	// Internal reset stretch
		@(negedge iCLK_50);
		check_flag("adc_cs", 1'b1, adc_cs);
		check_flag("adc_dclk", 1'b0, adc_dclk);
		check_flag("led_win", 1'b0, led_win);
		check_flag("led_lose", 1'b0, led_lose);
		for (int i = 3; i < 8; i++)
			check_digit($sformatf("digit %0d after reset", i), BLANK, hex[i]);
		for (int pc = 0; pc < vec_count; pc++)
		begin
			w = vec[pc];
			case (w[31:28])
				4'h1:
				begin
					for (int i = 0; i < 4; i++)
						code[i] = mastermind_pkg::colour_t'(w[14-4*i -: 3]);	// Slot 0 leftmost
					start_game(code);
				end
				4'h2: press(key_x(w[2:0]), Y_KEYPAD, 1);
				4'h3: press(key_x(w[2:0]), Y_LOWER, 1);
				4'h4: press(key_x(w[2:0]), Y_KEYPAD, 3);	// Pen held over three pairs
				4'h5: check_result(w);
				4'h6: check_guess(w);
				4'h8:
				begin
					for (int i = 0; i < 4; i++)
						press(key_x(w[14-4*i -: 3]), Y_KEYPAD, 1);
					press(key_x(3'd7), Y_KEYPAD, 1);	// Submit
				end
				default: fail_now("unknown operation in vector file");
			endcase
		end
		if (i_mastermind_top.i_mastermind_game.i_mastermind_assertions.fail_count > 0)
			fail_now("a bound assertion in mastermind_game failed");
		else
		begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb/mastermind_vectors.txt
// Top digit is the operation: 1 start, secret slots 0..3 in the low four digits; 2 key press;
// 3 lower-half press; 4 held press; 5 check black white rows win lose; 6 check count, slots; 8 guess+submit; F end
1000_0123
5000_0000
2000_0000
2000_0001
6002_0100
2000_0002
2000_0003
2000_0004
6004_0123
2000_0006
6000_0000
3000_0005
6000_0000
4000_0005
6001_5000
2000_0006
8000_1032
5000_4100
8000_0011
5001_1200
6000_0000
8000_0123
5004_0310
2000_0005
6000_0000
5004_0310
1000_5544
8000_4455
5000_4100
8000_5454
5002_2200
8000_0123
8000_0000
8000_0000
8000_0000
8000_0000
8000_5540
5003_0801
1000_2221
5000_0000
8000_1232
5001_2100
F000_0000

//--- src.f
verilog/touch_pkg.sv
verilog/mastermind_pkg.sv
verilog/reset_delay.sv
verilog/adc_spi_controller.sv
verilog/touch_zone_decoder.sv
verilog/peg_scorer.sv
verilog/mastermind_game.sv
verilog/seg7_display.sv
verilog/mastermind_top.sv
tb/mastermind_assertions.sv
tb/tb_mastermind.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module tb_mastermind -o sim_mastermind &&
./obj_dir/sim_mastermind || exit 1
